// ==== src/apb_periph_pkg.sv ====
/*
 * peripheral bus package
 * memory-bus and APB4 request/response structs, slave map,
 * register offsets, LFSR taps and the byte-strobe merge helper
 */
package apb_periph_pkg;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [ 3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // broadcast to every slave, psel travels separately
  typedef struct packed {
    logic [31:0] paddr;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [ 3:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
  } apb_rsp_t;

  // slave map, addr[15:12] picks the slave
  localparam int APB_SLAVES_NUM = 3;
  localparam int SLV_SEL_LSB    = 12;
  localparam int SLV_ARCHINFO   = 0;
  localparam int SLV_RNG        = 1;
  localparam int SLV_PWM        = 2;

  localparam logic [31:0] ARCH_ID  = 32'h5250_4331;
  // fibonacci taps 31, 21, 1, 0
  localparam logic [31:0] RNG_TAPS = 32'h8020_0003;
  localparam int          PWM_CH_NUM = 4;

  // archinfo
  localparam logic [11:0] REG_ID      = 12'h000;
  localparam logic [11:0] REG_SCRATCH = 12'h004;

  // rng
  localparam logic [11:0] REG_RNG_CTRL = 12'h000;
  localparam logic [11:0] REG_RNG_SEED = 12'h004;
  localparam logic [11:0] REG_RNG_VAL  = 12'h008;

  // pwm
  localparam logic [11:0] REG_PWM_CTRL   = 12'h000;
  localparam logic [11:0] REG_PWM_PSC    = 12'h004;
  localparam logic [11:0] REG_PWM_PERIOD = 12'h008;
  localparam logic [11:0] REG_PWM_CMP0   = 12'h00C;
  localparam logic [11:0] REG_PWM_CMP1   = 12'h010;
  localparam logic [11:0] REG_PWM_CMP2   = 12'h014;
  localparam logic [11:0] REG_PWM_CMP3   = 12'h018;
  localparam logic [11:0] REG_PWM_STAT   = 12'h01C;

  // replace the strobed bytes of old_val with those of new_val
  function automatic logic [31:0] strb_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [ 3:0] strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b+:8] = new_val[8*b+:8];
      end
    end
    return res;
  endfunction

endpackage

// ==== src/mem2apb.sv ====
/*
 * memory-bus to APB4 bridge
 * idle/setup/access FSM, slave decode from addr[15:12], read-data mux
 */
module mem2apb (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  apb_periph_pkg::mem_req_t                  mem_req_i,
  output apb_periph_pkg::mem_rsp_t                  mem_rsp_o,
  output apb_periph_pkg::apb_req_t                  apb_req_o,
  output logic [apb_periph_pkg::APB_SLAVES_NUM-1:0] apb_psel_o,
  input  apb_periph_pkg::apb_rsp_t [apb_periph_pkg::APB_SLAVES_NUM-1:0] apb_rsp_i
);
  import apb_periph_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e                    state_q;
  logic [APB_SLAVES_NUM-1:0] psel_q;
  logic [APB_SLAVES_NUM-1:0] psel_dec;
  logic                      penable_q;
  logic                      ready_q;
  logic [31:0]               rdata_q;
  logic [31:0]               paddr_q;
  logic [31:0]               pwdata_q;
  logic                      pwrite_q;
  logic [ 3:0]               pstrb_q;
  logic [ 3:0]               slv_field;
  logic                      accept;
  logic                      sel_pready;
  logic [31:0]               sel_prdata;

  assign slv_field = mem_req_i.addr[SLV_SEL_LSB+:4];

  always_comb begin
    for (int i = 0; i < APB_SLAVES_NUM; i++) begin
      psel_dec[i] = (slv_field == 4'(i));
    end
  end

  always_comb begin
    sel_pready = 1'b0;
    sel_prdata = '0;
    for (int i = 0; i < APB_SLAVES_NUM; i++) begin
      if (psel_q[i]) begin
        sel_pready = sel_pready | apb_rsp_i[i].pready;
        sel_prdata = sel_prdata | apb_rsp_i[i].prdata;
      end
    end
  end

  // valid is still high during the ready cycle, so skip it
  assign accept = (state_q == ST_IDLE) && mem_req_i.valid && !ready_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_IDLE;
      psel_q    <= '0;
      penable_q <= 1'b0;
      ready_q   <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (accept && (psel_dec != '0)) begin
            psel_q  <= psel_dec;
            state_q <= ST_SETUP;
          end else if (accept) begin
            // unmapped, answer at once
            ready_q <= 1'b1;
          end
        end
        ST_SETUP: begin
          penable_q <= 1'b1;
          state_q   <= ST_ACCESS;
        end
        ST_ACCESS: begin
          if (sel_pready) begin
            psel_q    <= '0;
            penable_q <= 1'b0;
            ready_q   <= 1'b1;
            state_q   <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q  <= mem_req_i.addr;
      pwdata_q <= mem_req_i.wdata;
      pstrb_q  <= mem_req_i.wstrb;
      pwrite_q <= |mem_req_i.wstrb;
      rdata_q  <= '0;
    end else if (state_q == ST_ACCESS && sel_pready) begin
      rdata_q <= sel_prdata;
    end
  end

  assign apb_req_o = '{paddr: paddr_q, penable: penable_q, pwrite: pwrite_q,
                       pwdata: pwdata_q, pstrb: pstrb_q};
  assign apb_psel_o = psel_q;
  assign mem_rsp_o  = '{ready: ready_q, rdata: rdata_q};

  a_psel_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(psel_q));
  a_penable_after_psel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    penable_q |-> (psel_q != '0) && ($past(psel_q) == psel_q));
  a_paddr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    penable_q |-> $stable(paddr_q));

endmodule

// ==== src/apb4_archinfo.sv ====
/*
 * architecture-info APB4 slave
 * read-only identifier and a byte-writable scratch register
 */
module apb4_archinfo (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  apb_periph_pkg::apb_req_t apb_req_i,
  input  logic                     apb_psel_i,
  output apb_periph_pkg::apb_rsp_t apb_rsp_o
);
  import apb_periph_pkg::*;

  logic [31:0] scratch_q;
  logic [11:0] offset;
  logic        wr_en;

  assign offset = apb_req_i.paddr[11:0];
  assign wr_en  = apb_psel_i && apb_req_i.penable && apb_req_i.pwrite;

  // id writes fall through and are dropped
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scratch_q <= '0;
    end else if (wr_en && offset == REG_SCRATCH) begin
      scratch_q <= strb_merge(scratch_q, apb_req_i.pwdata, apb_req_i.pstrb);
    end
  end

  always_comb begin
    apb_rsp_o.pready = 1'b1;
    case (offset)
      REG_ID:      apb_rsp_o.prdata = ARCH_ID;
      REG_SCRATCH: apb_rsp_o.prdata = scratch_q;
      default:     apb_rsp_o.prdata = '0;
    endcase
  end

endmodule

// ==== src/apb4_rng.sv ====
/*
 * random-number APB4 slave
 * 32-bit fibonacci LFSR, seed load, step on each enabled value read
 */
module apb4_rng (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  apb_periph_pkg::apb_req_t apb_req_i,
  input  logic                     apb_psel_i,
  output apb_periph_pkg::apb_rsp_t apb_rsp_o
);
  import apb_periph_pkg::*;

  logic        en_q;
  logic [31:0] state_q;
  logic [31:0] state_nxt;
  logic [31:0] seed_val;
  logic [11:0] offset;
  logic        access;
  logic        wr_en;
  logic        rd_val;

  assign offset = apb_req_i.paddr[11:0];
  assign access = apb_psel_i && apb_req_i.penable;
  assign wr_en  = access && apb_req_i.pwrite;
  assign rd_val = access && !apb_req_i.pwrite && (offset == REG_RNG_VAL);

  // new lsb is the parity of the tapped bits
  assign state_nxt = {state_q[30:0], ^(state_q & RNG_TAPS)};
  assign seed_val  = (apb_req_i.pwdata == '0) ? 32'd1 : apb_req_i.pwdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q    <= 1'b0;
      state_q <= 32'd1;
    end else begin
      if (wr_en && offset == REG_RNG_CTRL) begin
        en_q <= apb_req_i.pwdata[0];
      end
      if (wr_en && offset == REG_RNG_SEED) begin
        state_q <= seed_val;
      end else if (rd_val && en_q) begin
        state_q <= state_nxt;
      end
    end
  end

  always_comb begin
    apb_rsp_o.pready = 1'b1;
    case (offset)
      REG_RNG_CTRL: apb_rsp_o.prdata = {31'b0, en_q};
      REG_RNG_SEED: apb_rsp_o.prdata = state_q;
      REG_RNG_VAL:  apb_rsp_o.prdata = state_q;
      default:      apb_rsp_o.prdata = '0;
    endcase
  end

  a_state_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    state_q != '0);

endmodule

// ==== src/apb4_pwm.sv ====
/*
 * four-channel PWM APB4 slave
 * prescaler, period counter, per-channel compare, wrap status and irq
 */
module apb4_pwm (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  apb_periph_pkg::apb_req_t              apb_req_i,
  input  logic                                  apb_psel_i,
  output apb_periph_pkg::apb_rsp_t              apb_rsp_o,
  output logic [apb_periph_pkg::PWM_CH_NUM-1:0] pwm_o,
  output logic                                  irq_o
);
  import apb_periph_pkg::*;

  logic                        en_q;
  logic                        ie_q;
  logic                        stat_q;
  logic [15:0]                 psc_q;
  logic [15:0]                 period_q;
  logic [PWM_CH_NUM-1:0][15:0] cmp_q;
  logic [15:0]                 psc_cnt_q;
  logic [15:0]                 cnt_q;
  logic [PWM_CH_NUM-1:0]       cmp_sel;
  logic [31:0]                 rd_data;
  logic [31:0]                 wr_data;
  logic [11:0]                 offset;
  logic                        wr_en;
  logic                        tick;
  logic                        wrap;

  assign offset  = apb_req_i.paddr[11:0];
  assign wr_en   = apb_psel_i && apb_req_i.penable && apb_req_i.pwrite;
  assign wr_data = strb_merge(rd_data, apb_req_i.pwdata, apb_req_i.pstrb);

  assign tick = en_q && (psc_cnt_q >= psc_q);
  assign wrap = tick && (({1'b0, cnt_q} + 17'd1) >= {1'b0, period_q});

  always_comb begin
    cmp_sel = '0;
    rd_data = '0;
    case (offset)
      REG_PWM_CTRL:   rd_data = {30'b0, ie_q, en_q};
      REG_PWM_PSC:    rd_data = {16'b0, psc_q};
      REG_PWM_PERIOD: rd_data = {16'b0, period_q};
      REG_PWM_CMP0:   cmp_sel[0] = 1'b1;
      REG_PWM_CMP1:   cmp_sel[1] = 1'b1;
      REG_PWM_CMP2:   cmp_sel[2] = 1'b1;
      REG_PWM_CMP3:   cmp_sel[3] = 1'b1;
      REG_PWM_STAT:   rd_data = {31'b0, stat_q};
      default:        rd_data = '0;
    endcase
    for (int n = 0; n < PWM_CH_NUM; n++) begin
      if (cmp_sel[n]) begin
        rd_data = {16'b0, cmp_q[n]};
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q     <= 1'b0;
      ie_q     <= 1'b0;
      psc_q    <= '0;
      period_q <= '0;
      cmp_q    <= '0;
    end else if (wr_en) begin
      if (offset == REG_PWM_CTRL) begin
        {ie_q, en_q} <= wr_data[1:0];
      end
      if (offset == REG_PWM_PSC) begin
        psc_q <= wr_data[15:0];
      end
      if (offset == REG_PWM_PERIOD) begin
        period_q <= wr_data[15:0];
      end
      for (int n = 0; n < PWM_CH_NUM; n++) begin
        if (cmp_sel[n]) begin
          cmp_q[n] <= wr_data[15:0];
        end
      end
    end
  end

  // a new period restarts the count
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      psc_cnt_q <= '0;
      cnt_q     <= '0;
    end else if (!en_q || (wr_en && offset == REG_PWM_PERIOD)) begin
      psc_cnt_q <= '0;
      cnt_q     <= '0;
    end else if (tick) begin
      psc_cnt_q <= '0;
      cnt_q     <= wrap ? 16'd0 : cnt_q + 16'd1;
    end else begin
      psc_cnt_q <= psc_cnt_q + 16'd1;
    end
  end

  // set on wrap wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stat_q <= 1'b0;
    end else if (wrap) begin
      stat_q <= 1'b1;
    end else if (wr_en && offset == REG_PWM_STAT && apb_req_i.pstrb[0] &&
                 apb_req_i.pwdata[0]) begin
      stat_q <= 1'b0;
    end
  end

  always_comb begin
    for (int n = 0; n < PWM_CH_NUM; n++) begin
      pwm_o[n] = en_q && (cnt_q < cmp_q[n]);
    end
  end

  assign irq_o = stat_q && ie_q;

  assign apb_rsp_o.pready = 1'b1;
  assign apb_rsp_o.prdata = rd_data;

  a_cnt_below_period: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (period_q != '0) |-> (cnt_q < period_q));

endmodule

// ==== src/ip_apb_wrapper.sv ====
/*
 * peripheral subsystem top
 * bridge plus archinfo, rng and pwm slaves on one APB4 bus
 */
module ip_apb_wrapper (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  apb_periph_pkg::mem_req_t              mem_req_i,
  output apb_periph_pkg::mem_rsp_t              mem_rsp_o,
  output logic [apb_periph_pkg::PWM_CH_NUM-1:0] pwm_o,
  output logic                                  pwm_irq_o
);
  import apb_periph_pkg::*;

  apb_req_t                      apb_req;
  logic [APB_SLAVES_NUM-1:0]     apb_psel;
  apb_rsp_t [APB_SLAVES_NUM-1:0] apb_rsp;

  mem2apb u_mem2apb (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .mem_req_i (mem_req_i),
    .mem_rsp_o (mem_rsp_o),
    .apb_req_o (apb_req),
    .apb_psel_o(apb_psel),
    .apb_rsp_i (apb_rsp)
  );

  apb4_archinfo u_apb4_archinfo (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req),
    .apb_psel_i(apb_psel[SLV_ARCHINFO]),
    .apb_rsp_o (apb_rsp[SLV_ARCHINFO])
  );

  apb4_rng u_apb4_rng (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req),
    .apb_psel_i(apb_psel[SLV_RNG]),
    .apb_rsp_o (apb_rsp[SLV_RNG])
  );

  apb4_pwm u_apb4_pwm (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req),
    .apb_psel_i(apb_psel[SLV_PWM]),
    .apb_rsp_o (apb_rsp[SLV_PWM]),
    .pwm_o     (pwm_o),
    .irq_o     (pwm_irq_o)
  );

endmodule

// ==== sim/tb_ip_apb_wrapper.sv ====
/*
 * testbench for the APB peripheral subsystem
 * bus tasks, reference models, protocol assertions,
 * per-block tests, timeout and final report
 */
module tb_ip_apb_wrapper;
  timeunit 1ns;
  timeprecision 1ps;

  import apb_periph_pkg::*;

  // bus traffic plus the pwm windows, with a wide margin
  localparam int MAX_CYCLES = 20000;

  logic                  clk;
  logic                  arst_n;
  mem_req_t              mem_req;
  mem_rsp_t              mem_rsp;
  logic [PWM_CH_NUM-1:0] pwm;
  logic                  pwm_irq;

  logic [31:0] lfsr_state = 32'h4dcf;
  int          cycles;
  int          requests;
  int          ready_pulses;
  int          value_errors;
  int          protocol_errors;

  ip_apb_wrapper ip_apb_wrapper_i (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .mem_req_i(mem_req),
    .mem_rsp_o(mem_rsp),
    .pwm_o    (pwm),
    .pwm_irq_o(pwm_irq)
  );

  always #4 clk = ~clk;

  // stimulus source, taps 32, 30, 26, 25
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] res;
    logic        fb;
    res = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[29] ^ lfsr_state[25] ^ lfsr_state[24];
      lfsr_state = {lfsr_state[30:0], fb};
      res        = {res[30:0], fb};
    end
    return res;
  endfunction

  // reference for the rng block, taps 31, 21, 1, 0
  function automatic logic [31:0] rng_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] byte_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [ 3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  // high clocks of one channel over whole periods
  function automatic int expected_high(input int cmp, input int period, input int psc,
                                       input int periods);
    int on_counts;
    on_counts = (cmp < period) ? cmp : period;
    return on_counts * (psc + 1) * periods;
  endfunction

  function automatic logic [31:0] reg_addr(input int slv, input logic [11:0] off);
    return {16'b0, 4'(slv), off};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic protocol_error(input string what);
    protocol_errors++;
    $display("protocol error: %s", what);
  endtask

  // one request, held until ready
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata);
    @(negedge clk);
    mem_req.valid = 1'b1;
    mem_req.addr  = addr;
    mem_req.wdata = wdata;
    mem_req.wstrb = strb;
    requests++;
    do @(negedge clk); while (!mem_rsp.ready);
    rdata         = mem_rsp.rdata;
    mem_req.valid = 1'b0;
    mem_req.wstrb = 4'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb = 4'hf);
    logic [31:0] unused;
    bus_access(addr, data, strb, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 32'h0, 4'h0, data);
  endtask

  always @(negedge clk) begin
    if (mem_rsp.ready) begin
      ready_pulses++;
    end
  end

  a_ready_single: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rsp.ready |=> !mem_rsp.ready)
    else protocol_error("ready stayed high for more than one cycle");
  a_ready_after_valid: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rsp.ready |-> $past(mem_req.valid))
    else protocol_error("ready came without a pending request");

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic test_protocol();
    logic [31:0] rd;
    check_value("ready after reset", 32'h0, {31'b0, mem_rsp.ready});
    check_value("irq after reset", 32'h0, {31'b0, pwm_irq});
    check_value("pwm after reset", 32'h0, 32'(pwm));
    bus_read(32'h0000_3000, rd);
    check_value("unmapped read", 32'h0, rd);
    bus_write(32'h0000_3000, 32'hdead_beef);
    bus_read(32'h0000_3000, rd);
    check_value("unmapped read after write", 32'h0, rd);
  endtask

  task automatic test_archinfo();
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] model;
    logic [31:0] rnd;
    logic [ 3:0] strb;
    bus_read(reg_addr(SLV_ARCHINFO, REG_ID), rd);
    check_value("archinfo id", ARCH_ID, rd);
    bus_write(reg_addr(SLV_ARCHINFO, REG_ID), rand_bits(32));
    bus_read(reg_addr(SLV_ARCHINFO, REG_ID), rd);
    check_value("archinfo id after write", ARCH_ID, rd);
    model = rand_bits(32);
    bus_write(reg_addr(SLV_ARCHINFO, REG_SCRATCH), model);
    bus_read(reg_addr(SLV_ARCHINFO, REG_SCRATCH), rd);
    check_value("scratch full write", model, rd);
    for (int i = 0; i < 16; i++) begin
      data = rand_bits(32);
      rnd  = rand_bits(4);
      // an empty strobe would turn the access into a read
      strb = (rnd[3:0] == 4'b0) ? 4'b0001 : rnd[3:0];
      bus_write(reg_addr(SLV_ARCHINFO, REG_SCRATCH), data, strb);
      model = byte_merge(model, data, strb);
      bus_read(reg_addr(SLV_ARCHINFO, REG_SCRATCH), rd);
      check_value("scratch merge", model, rd);
    end
  endtask

  task automatic test_rng();
    logic [31:0] rd;
    logic [31:0] seed;
    logic [31:0] model;
    seed = rand_bits(32);
    bus_write(reg_addr(SLV_RNG, REG_RNG_CTRL), 32'h1);
    bus_write(reg_addr(SLV_RNG, REG_RNG_SEED), seed);
    model = (seed == 32'h0) ? 32'h1 : seed;
    for (int i = 0; i < 8; i++) begin
      bus_read(reg_addr(SLV_RNG, REG_RNG_VAL), rd);
      check_value("rng sequence", model, rd);
      model = rng_step(model);
    end
    bus_write(reg_addr(SLV_RNG, REG_RNG_CTRL), 32'h0);
    for (int i = 0; i < 4; i++) begin
      bus_read(reg_addr(SLV_RNG, REG_RNG_VAL), rd);
      check_value("rng held when disabled", model, rd);
    end
    bus_write(reg_addr(SLV_RNG, REG_RNG_SEED), 32'h0);
    bus_read(reg_addr(SLV_RNG, REG_RNG_VAL), rd);
    check_value("rng zero seed", 32'h1, rd);
  endtask

  task automatic test_pwm_duty();
    int          cmp_val [PWM_CH_NUM] = '{0, 3, 7, 12};
    int          high_cnt [PWM_CH_NUM];
    int          psc;
    int          period;
    int          periods;
    logic [31:0] rd;
    psc     = 1;
    period  = 10;
    periods = 10;
    bus_write(reg_addr(SLV_PWM, REG_PWM_PSC), 32'(psc));
    bus_write(reg_addr(SLV_PWM, REG_PWM_PERIOD), 32'(period));
    for (int n = 0; n < PWM_CH_NUM; n++) begin
      bus_write(reg_addr(SLV_PWM, REG_PWM_CMP0 + 12'(4 * n)), 32'(cmp_val[n]));
      high_cnt[n] = 0;
    end
    bus_write(reg_addr(SLV_PWM, REG_PWM_CTRL), 32'h1);
    bus_write(reg_addr(SLV_PWM, REG_PWM_STAT), 32'h1);
    do bus_read(reg_addr(SLV_PWM, REG_PWM_STAT), rd); while (rd[0] == 1'b0);
    bus_write(reg_addr(SLV_PWM, REG_PWM_STAT), 32'h1);
    // any window of whole periods gives the same count
    repeat (periods * period * (psc + 1)) begin
      @(negedge clk);
      for (int n = 0; n < PWM_CH_NUM; n++) begin
        if (pwm[n]) begin
          high_cnt[n]++;
        end
      end
    end
    bus_read(reg_addr(SLV_PWM, REG_PWM_STAT), rd);
    check_value("pwm wrap in window", 32'h1, rd);
    for (int n = 0; n < PWM_CH_NUM; n++) begin
      check_value($sformatf("pwm duty ch%0d", n),
                  32'(expected_high(cmp_val[n], period, psc, periods)), 32'(high_cnt[n]));
    end
  endtask

  task automatic test_pwm_irq();
    logic [31:0] rd;
    int          waited;
    int          irq_high;
    // stopped counter, so no wrap races the clear
    bus_write(reg_addr(SLV_PWM, REG_PWM_CTRL), 32'h0);
    bus_write(reg_addr(SLV_PWM, REG_PWM_STAT), 32'h1);
    bus_write(reg_addr(SLV_PWM, REG_PWM_CTRL), 32'h3);
    check_value("irq before wrap", 32'h0, {31'b0, pwm_irq});
    waited = 0;
    while (!pwm_irq && waited < 60) begin
      @(negedge clk);
      waited++;
    end
    check_value("irq after wrap", 32'h1, {31'b0, pwm_irq});
    bus_write(reg_addr(SLV_PWM, REG_PWM_CTRL), 32'h2);
    check_value("irq held while pending", 32'h1, {31'b0, pwm_irq});
    bus_write(reg_addr(SLV_PWM, REG_PWM_STAT), 32'h1);
    check_value("irq after clear", 32'h0, {31'b0, pwm_irq});
    bus_read(reg_addr(SLV_PWM, REG_PWM_STAT), rd);
    check_value("stat after clear", 32'h0, rd);
    bus_write(reg_addr(SLV_PWM, REG_PWM_CTRL), 32'h1);
    irq_high = 0;
    repeat (60) begin
      @(negedge clk);
      if (pwm_irq) begin
        irq_high++;
      end
    end
    check_value("irq masked cycles", 32'h0, 32'(irq_high));
    bus_read(reg_addr(SLV_PWM, REG_PWM_STAT), rd);
    check_value("stat with irq masked", 32'h1, rd);
  endtask

  initial begin
    clk     = 1'b0;
    arst_n  = 1'b0;
    mem_req = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    test_protocol();
    test_archinfo();
    test_rng();
    test_pwm_duty();
    test_pwm_irq();
    repeat (4) @(negedge clk);
    check_value("ready pulse count", 32'(requests), 32'(ready_pulses));
    $display("errors: %0d value, %0d protocol, over %0d requests",
             value_errors, protocol_errors, requests);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/apb_periph_pkg.sv
src/mem2apb.sv
src/apb4_archinfo.sv
src/apb4_rng.sv
src/apb4_pwm.sv
src/ip_apb_wrapper.sv
sim/tb_ip_apb_wrapper.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ip_apb_wrapper -f list.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "TEST OK" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
